/* rv32_core_pkg.sv */
// ************************************************
// Shared types for the two-stage RV32I core.
// Word and register types, opcode and ALU enums, the
// decode struct and the stage and memory structs.
// Modules refer to these by scoped names.
// ************************************************

package rv32_core_pkg;

  // Data, address and instruction word.
  typedef logic [31:0] word_t;
  // Register index.
  typedef logic [4:0] reg_addr_t;

  // RV32I major opcodes that the core executes.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Encoded as funct3 so decode is a plain cast.
  typedef enum logic [2:0] {BR_BEQ = 3'd0, BR_BNE = 3'd1, BR_BLT = 3'd4,
                            BR_BGE = 3'd5, BR_BLTU = 3'd6, BR_BGEU = 3'd7} branch_t;

  // Matches funct3[1:0] of loads and stores.
  typedef enum logic [1:0] {MEM_BYTE = 2'd0, MEM_HALF = 2'd1, MEM_WORD = 2'd2} mem_size_t;

  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} alu_a_sel_t;
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_t;

  // Decode result. All-zero fields form a no-op.
  typedef struct packed {
    alu_op_t    alu_op;
    alu_a_sel_t a_sel;
    alu_b_sel_t b_sel;
    wb_sel_t    wb_sel;
    logic       reg_wen;
    logic       mem_read;
    logic       mem_write;
    mem_size_t  mem_size;
    logic       load_unsigned;
    logic       branch;
    branch_t    branch_type;
    logic       jal;
    logic       jalr;
    logic       halt;
    word_t      imm;
  } ctrl_t;

  // Fetch-to-execute pipeline register.
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t pc4;
    word_t instr;
    logic  prediction;
  } fetch_ex_t;

  // Data memory request.
  typedef struct packed {
    logic       ren;
    logic       wen;
    logic [3:0] byte_en;
    word_t      addr;
    word_t      wdata;
  } mem_req_t;

  localparam word_t RESET_PC  = 32'h0000_0000;
  // ADDI x0, x0, 0.
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

/* reg_file.sv */
// ************************************************
// Integer register file.
// Two combinational read ports, one clocked write
// port. x0 always reads as zero.
// ************************************************

`timescale 1ns/1ps

module reg_file (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  rv32_core_pkg::reg_addr_t rs1,
  input  rv32_core_pkg::reg_addr_t rs2,
  input  rv32_core_pkg::reg_addr_t rd,
  input  logic                   wen,
  input  rv32_core_pkg::word_t   wdata,
  output rv32_core_pkg::word_t   rs1_data,
  output rv32_core_pkg::word_t   rs2_data
);

  // Entry 0 clears on reset and the write port skips it.
  rv32_core_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // A write aimed at x0 must leave it at zero.
  assert property (@(posedge CLK) disable iff (!rst_n)
    (wen && rd == '0) |=> regs[0] == '0);

endmodule

/* alu.sv */
// ************************************************
// Combinational RV32I ALU.
// Add, sub, logic, shifts and set-less-than.
// Shift amounts come from b[4:0].
// ************************************************

`timescale 1ns/1ps

module alu (
  input  rv32_core_pkg::alu_op_t op,
  input  rv32_core_pkg::word_t   a,
  input  rv32_core_pkg::word_t   b,
  output rv32_core_pkg::word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv32_core_pkg::ALU_ADD:  result = a + b;
      rv32_core_pkg::ALU_SUB:  result = a - b;
      rv32_core_pkg::ALU_AND:  result = a & b;
      rv32_core_pkg::ALU_OR:   result = a | b;
      rv32_core_pkg::ALU_XOR:  result = a ^ b;
      rv32_core_pkg::ALU_SLL:  result = a << shamt;
      rv32_core_pkg::ALU_SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign.
      rv32_core_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      rv32_core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv32_core_pkg::ALU_SLTU: result = {31'b0, a < b};
      default:                 result = '0;
    endcase
  end

endmodule

/* control_unit.sv */
// ************************************************
// Instruction decoder.
// Turns an instruction word into the control struct,
// including the sign-extended immediate. Unknown
// opcodes decode to a no-op.
// ************************************************

`timescale 1ns/1ps

module control_unit (
  input  rv32_core_pkg::word_t instr,
  output rv32_core_pkg::ctrl_t ctrl
);

  rv32_core_pkg::opcode_t opcode;
  logic [2:0]             funct3;
  logic                   alt;
  rv32_core_pkg::word_t   imm_i;
  rv32_core_pkg::word_t   imm_s;
  rv32_core_pkg::word_t   imm_b;
  rv32_core_pkg::word_t   imm_u;
  rv32_core_pkg::word_t   imm_j;

  // Maps funct3 to an ALU op; alt selects SUB and SRA.
  function automatic rv32_core_pkg::alu_op_t alu_decode(input logic [2:0] f3,
                                                        input logic alt_op);
    case (f3)
      3'b000:  return alt_op ? rv32_core_pkg::ALU_SUB : rv32_core_pkg::ALU_ADD;
      3'b001:  return rv32_core_pkg::ALU_SLL;
      3'b010:  return rv32_core_pkg::ALU_SLT;
      3'b011:  return rv32_core_pkg::ALU_SLTU;
      3'b100:  return rv32_core_pkg::ALU_XOR;
      3'b101:  return alt_op ? rv32_core_pkg::ALU_SRA : rv32_core_pkg::ALU_SRL;
      3'b110:  return rv32_core_pkg::ALU_OR;
      default: return rv32_core_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = rv32_core_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  // funct7[5] only matters for OP, and for the shifts of OP-IMM.
  assign alt    = instr[30] & (opcode == rv32_core_pkg::OPC_OP || funct3 == 3'b101);

  // Immediate formats.
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // Zero is ADD rs1+rs2 with nothing written.
    ctrl = '0;
    case (opcode)
      rv32_core_pkg::OPC_LUI: begin
        ctrl.a_sel   = rv32_core_pkg::A_ZERO;
        ctrl.b_sel   = rv32_core_pkg::B_IMM;
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_AUIPC: begin
        ctrl.a_sel   = rv32_core_pkg::A_PC;
        ctrl.b_sel   = rv32_core_pkg::B_IMM;
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_JAL: begin
        ctrl.jal     = 1'b1;
        ctrl.wb_sel  = rv32_core_pkg::WB_PC4;
        ctrl.imm     = imm_j;
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_JALR: begin
        ctrl.jalr    = 1'b1;
        ctrl.wb_sel  = rv32_core_pkg::WB_PC4;
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_BRANCH: begin
        ctrl.branch      = 1'b1;
        ctrl.branch_type = rv32_core_pkg::branch_t'(funct3);
        ctrl.imm         = imm_b;
      end
      rv32_core_pkg::OPC_LOAD: begin
        // Address is rs1 + imm through the ALU.
        ctrl.b_sel         = rv32_core_pkg::B_IMM;
        ctrl.imm           = imm_i;
        ctrl.mem_read      = 1'b1;
        ctrl.mem_size      = rv32_core_pkg::mem_size_t'(funct3[1:0]);
        ctrl.load_unsigned = funct3[2];
        ctrl.wb_sel        = rv32_core_pkg::WB_LOAD;
        ctrl.reg_wen       = 1'b1;
      end
      rv32_core_pkg::OPC_STORE: begin
        ctrl.b_sel     = rv32_core_pkg::B_IMM;
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.mem_size  = rv32_core_pkg::mem_size_t'(funct3[1:0]);
      end
      rv32_core_pkg::OPC_OP_IMM: begin
        ctrl.alu_op  = alu_decode(funct3, alt);
        ctrl.b_sel   = rv32_core_pkg::B_IMM;
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_OP: begin
        ctrl.alu_op  = alu_decode(funct3, alt);
        ctrl.reg_wen = 1'b1;
      end
      rv32_core_pkg::OPC_SYSTEM: begin
        // Only EBREAK is honoured.
        ctrl.halt = (instr == 32'h0010_0073);
      end
      default: ;
    endcase
  end

endmodule

/* branch_unit.sv */
// ************************************************
// Branch and jump resolution.
// Evaluates the six branch conditions and forms the
// branch, JAL and JALR targets. Jumps are always taken.
// ************************************************

`timescale 1ns/1ps

module branch_unit (
  input  rv32_core_pkg::ctrl_t ctrl,
  input  rv32_core_pkg::word_t pc,
  input  rv32_core_pkg::word_t rs1_data,
  input  rv32_core_pkg::word_t rs2_data,
  output logic                 taken,
  output rv32_core_pkg::word_t target
);

  logic cond;

  always_comb begin
    case (ctrl.branch_type)
      rv32_core_pkg::BR_BEQ:  cond = (rs1_data == rs2_data);
      rv32_core_pkg::BR_BNE:  cond = (rs1_data != rs2_data);
      rv32_core_pkg::BR_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      rv32_core_pkg::BR_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      rv32_core_pkg::BR_BLTU: cond = (rs1_data < rs2_data);
      rv32_core_pkg::BR_BGEU: cond = (rs1_data >= rs2_data);
      default:                cond = 1'b0;
    endcase
  end

  // JALR is register relative with bit zero cleared.
  assign target = ctrl.jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : (pc + ctrl.imm);
  assign taken  = ctrl.jal | ctrl.jalr | (ctrl.branch & cond);

endmodule

/* hazard_unit.sv */
// ************************************************
// Pipeline hazard control.
// Stalls both stages on a busy data access, flushes
// fetch on a jump or mispredict, freezes fetch on halt.
// ************************************************

`timescale 1ns/1ps

module hazard_unit (
  input  logic dmem_busy,
  input  logic mem_access,
  input  logic mispredict,
  input  logic jump,
  input  logic halt,
  output logic stall,
  output logic flush,
  output logic ex_stall
);

  always_comb begin
    // Execute waits only on the data memory.
    ex_stall = mem_access & dmem_busy;
    stall    = ex_stall | halt;
    // A redirect waits until the stage is free to move.
    flush    = (mispredict | jump) & ~stall;
  end

endmodule

/* fetch_stage.sv */
// ************************************************
// Fetch stage.
// Holds the PC, drives the instruction port, predicts
// backward branches taken, and loads the register that
// feeds execute. Busy memory inserts a bubble.
// ************************************************

`timescale 1ns/1ps

module fetch_stage (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     stall,
  input  logic                     flush,
  input  logic                     halt,
  input  rv32_core_pkg::word_t     brj_addr,
  output logic                     imem_ren,
  output rv32_core_pkg::word_t     imem_addr,
  input  rv32_core_pkg::word_t     imem_rdata,
  input  logic                     imem_busy,
  output rv32_core_pkg::fetch_ex_t fetch_ex
);

  rv32_core_pkg::word_t pc;
  rv32_core_pkg::word_t pc4;
  rv32_core_pkg::word_t pred_target;
  rv32_core_pkg::word_t imm_b;
  logic                 predict;

  assign pc4       = pc + 32'd4;
  assign imem_addr = pc;
  // No requests after halt.
  assign imem_ren  = ~halt;

  // Static predictor. A negative B offset is a loop, so taken.
  assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                  imem_rdata[30:25], imem_rdata[11:8], 1'b0};
  assign predict = (imem_rdata[6:0] == rv32_core_pkg::OPC_BRANCH) & imem_rdata[31];
  assign pred_target = pc + imm_b;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc             <= rv32_core_pkg::RESET_PC;
      fetch_ex       <= '0;
      fetch_ex.instr <= rv32_core_pkg::NOP_INSTR;
    end else if (flush) begin
      // Redirect and kill the wrong-path slot.
      pc             <= brj_addr;
      fetch_ex       <= '0;
      fetch_ex.instr <= rv32_core_pkg::NOP_INSTR;
    end else if (stall) begin
      // Hold PC and the slot in execute.
    end else if (imem_busy) begin
      // Same address next cycle, bubble into execute.
      fetch_ex       <= '0;
      fetch_ex.instr <= rv32_core_pkg::NOP_INSTR;
    end else begin
      pc                  <= predict ? pred_target : pc4;
      fetch_ex.valid      <= 1'b1;
      fetch_ex.pc         <= pc;
      fetch_ex.pc4        <= pc4;
      fetch_ex.instr      <= imem_rdata;
      fetch_ex.prediction <= predict;
    end
  end

  // Targets come from the program, so alignment is worth watching.
  assert property (@(posedge CLK) disable iff (!rst_n)
    imem_ren |-> imem_addr[1:0] == 2'b00);

endmodule

/* execute_stage.sv */
// ************************************************
// Execute stage.
// Decodes, reads registers, runs the ALU, resolves
// branches and jumps, drives the data port and writes
// back. Reports redirects and memory use to hazards.
// ************************************************

`timescale 1ns/1ps

module execute_stage (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  rv32_core_pkg::fetch_ex_t fetch_ex,
  input  logic                     ex_stall,
  output rv32_core_pkg::word_t     brj_addr,
  output logic                     mispredict,
  output logic                     jump,
  output logic                     mem_access,
  output logic                     halt,
  output rv32_core_pkg::mem_req_t  dmem_req,
  input  rv32_core_pkg::word_t     dmem_rdata
);

  rv32_core_pkg::ctrl_t ctrl;
  rv32_core_pkg::word_t rs1_data;
  rv32_core_pkg::word_t rs2_data;
  rv32_core_pkg::word_t alu_a;
  rv32_core_pkg::word_t alu_b;
  rv32_core_pkg::word_t alu_result;
  rv32_core_pkg::word_t target;
  rv32_core_pkg::word_t load_shift;
  rv32_core_pkg::word_t load_data;
  rv32_core_pkg::word_t wb_data;
  logic                 taken;
  logic                 halt_q;
  logic                 rf_wen;

  control_unit u_control_unit (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  reg_file u_reg_file (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rs1      (fetch_ex.instr[19:15]),
    .rs2      (fetch_ex.instr[24:20]),
    .rd       (fetch_ex.instr[11:7]),
    .wen      (rf_wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  branch_unit u_branch_unit (
    .ctrl     (ctrl),
    .pc       (fetch_ex.pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (taken),
    .target   (target)
  );

  // Operand A: rs1, PC for AUIPC, zero for LUI.
  always_comb begin
    case (ctrl.a_sel)
      rv32_core_pkg::A_PC:   alu_a = fetch_ex.pc;
      rv32_core_pkg::A_ZERO: alu_a = '0;
      default:               alu_a = rs1_data;
    endcase
  end
  assign alu_b = (ctrl.b_sel == rv32_core_pkg::B_IMM) ? ctrl.imm : rs2_data;

  // Bring the addressed lane down to bit 0, then extend.
  assign load_shift = dmem_rdata >> {alu_result[1:0], 3'b000};
  always_comb begin
    case (ctrl.mem_size)
      rv32_core_pkg::MEM_BYTE:
        load_data = {{24{~ctrl.load_unsigned & load_shift[7]}}, load_shift[7:0]};
      rv32_core_pkg::MEM_HALF:
        load_data = {{16{~ctrl.load_unsigned & load_shift[15]}}, load_shift[15:0]};
      default:
        load_data = load_shift;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      rv32_core_pkg::WB_LOAD: wb_data = load_data;
      rv32_core_pkg::WB_PC4:  wb_data = fetch_ex.pc4;
      default:                wb_data = alu_result;
    endcase
  end

  // Retire only when the slot is live and memory is done.
  assign rf_wen = fetch_ex.valid & ctrl.reg_wen & ~ex_stall;

  // Data request. Store data is replicated, byte_en picks the lane.
  assign dmem_req.ren  = fetch_ex.valid & ctrl.mem_read;
  assign dmem_req.wen  = fetch_ex.valid & ctrl.mem_write;
  assign dmem_req.addr = alu_result;
  always_comb begin
    case (ctrl.mem_size)
      rv32_core_pkg::MEM_BYTE: begin
        dmem_req.byte_en = 4'b0001 << alu_result[1:0];
        dmem_req.wdata   = {4{rs2_data[7:0]}};
      end
      rv32_core_pkg::MEM_HALF: begin
        dmem_req.byte_en = alu_result[1] ? 4'b1100 : 4'b0011;
        dmem_req.wdata   = {2{rs2_data[15:0]}};
      end
      default: begin
        dmem_req.byte_en = 4'b1111;
        dmem_req.wdata   = rs2_data;
      end
    endcase
  end

  assign mem_access = dmem_req.ren | dmem_req.wen;
  assign jump       = fetch_ex.valid & (ctrl.jal | ctrl.jalr);
  // Wrong guess in either direction.
  assign mispredict = fetch_ex.valid & ctrl.branch & (fetch_ex.prediction ^ taken);
  // Not-taken redirect falls back to pc4.
  assign brj_addr   = taken ? target : fetch_ex.pc4;

  // Halt is sticky from the first cycle EBREAK sits here.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      halt_q <= 1'b0;
    end else if (fetch_ex.valid && ctrl.halt) begin
      halt_q <= 1'b1;
    end
  end
  assign halt = halt_q | (fetch_ex.valid & ctrl.halt);

  assert property (@(posedge CLK) disable iff (!rst_n)
    !(dmem_req.ren && dmem_req.wen));

  // Nothing leaves the core once halted.
  assert property (@(posedge CLK) disable iff (!rst_n)
    halt |=> !(dmem_req.ren || dmem_req.wen));

endmodule

/* rv32_core.sv */
// ************************************************
// Two-stage RV32I core top level.
// Connects fetch, execute and the hazard unit to the
// instruction and data memory ports.
// ************************************************

`timescale 1ns/1ps

module rv32_core (
  input  logic                    CLK,
  input  logic                    rst_n,
  output logic                    imem_ren,
  output rv32_core_pkg::word_t    imem_addr,
  input  rv32_core_pkg::word_t    imem_rdata,
  input  logic                    imem_busy,
  output rv32_core_pkg::mem_req_t dmem_req,
  input  rv32_core_pkg::word_t    dmem_rdata,
  input  logic                    dmem_busy,
  output logic                    halt
);

  rv32_core_pkg::fetch_ex_t fetch_ex;
  rv32_core_pkg::word_t     brj_addr;
  logic                     mispredict;
  logic                     jump;
  logic                     mem_access;
  logic                     stall;
  logic                     flush;
  logic                     ex_stall;

  fetch_stage u_fetch_stage (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (flush),
    .halt       (halt),
    .brj_addr   (brj_addr),
    .imem_ren   (imem_ren),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .imem_busy  (imem_busy),
    .fetch_ex   (fetch_ex)
  );

  execute_stage u_execute_stage (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .fetch_ex   (fetch_ex),
    .ex_stall   (ex_stall),
    .brj_addr   (brj_addr),
    .mispredict (mispredict),
    .jump       (jump),
    .mem_access (mem_access),
    .halt       (halt),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  hazard_unit u_hazard_unit (
    .dmem_busy  (dmem_busy),
    .mem_access (mem_access),
    .mispredict (mispredict),
    .jump       (jump),
    .halt       (halt),
    .stall      (stall),
    .flush      (flush),
    .ex_stall   (ex_stall)
  );

endmodule

/* tb_rv32_core.sv */
// ************************************************
// Testbench for the two-stage RV32I core.
// Models both memories, assembles a test program with
// encoding functions, throttles the data port with an
// LFSR and checks every store against a scoreboard.
// ************************************************

`timescale 1ns/1ps

module tb_rv32_core;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 64;

  logic                    CLK = 1'b0;
  logic                    rst_n;
  logic                    imem_ren;
  rv32_core_pkg::word_t    imem_addr;
  rv32_core_pkg::word_t    imem_rdata;
  logic                    imem_busy;
  rv32_core_pkg::mem_req_t dmem_req;
  rv32_core_pkg::word_t    dmem_rdata;
  logic                    dmem_busy;
  logic                    halt;

  rv32_core_pkg::word_t imem [IMEM_WORDS];
  rv32_core_pkg::word_t dmem [DMEM_WORDS];
  // Expected stores as {addr, byte_en, wdata}.
  logic [67:0]          exp_q [$];
  string                name_q [$];
  int                   check_errors = 0;
  int                   other_errors = 0;
  int                   pc_idx = 0;
  rv32_core_pkg::word_t store_addr = '0;
  logic [31:0]          lfsr = 32'hf1ba08a8;
  logic                 busy_bit0;
  logic                 busy_bit1;

  always #4 CLK = ~CLK;

  rv32_core u_dut (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .imem_busy  (imem_busy),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .dmem_busy  (dmem_busy),
    .halt       (halt)
  );

  // Instruction memory always answers at once.
  assign imem_busy  = 1'b0;
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  // Instruction encoders, one per format.
  function automatic rv32_core_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv32_core_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32_core_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32_core_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32_core_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv32_core_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv32_core_pkg::word_t sext8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic rv32_core_pkg::word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // Galois LFSR, one step per bit.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic emit(input rv32_core_pkg::word_t ins);
    imem[pc_idx] = ins;
    pc_idx++;
  endtask

  task automatic expect_store(input string name, input rv32_core_pkg::word_t addr,
      input logic [3:0] be, input rv32_core_pkg::word_t data);
    exp_q.push_back({addr, be, data});
    name_q.push_back(name);
  endtask

  // SW of one register to the next result slot.
  task automatic check_word(input string name, input logic [4:0] rs,
      input rv32_core_pkg::word_t value);
    emit(s_type(store_addr[11:0], rs, 5'd0, 3'b010));
    expect_store(name, store_addr, 4'hf, value);
    store_addr += 32'd4;
  endtask

  // Register-register op on x1 and x2 into x3.
  task automatic alu_rr(input string name, input logic [6:0] f7, input logic [2:0] f3,
      input rv32_core_pkg::word_t value);
    emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    check_word(name, 5'd3, value);
  endtask

  task automatic alu_ri(input string name, input logic [11:0] imm, input logic [2:0] f3,
      input rv32_core_pkg::word_t value);
    emit(i_type(imm, 5'd1, f3, 5'd3, rv32_core_pkg::OPC_OP_IMM));
    check_word(name, 5'd3, value);
  endtask

  task automatic build_program;
    rv32_core_pkg::word_t here;
    // Unused slot i holds a store to 4*i that no test expects.
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = s_type(12'(4 * i), 5'd1, 5'd0, 3'b010);
    end
    // Operands are x1 = -7 and x2 = 3.
    emit(i_type(12'hff9, 5'd0, 3'b000, 5'd1, rv32_core_pkg::OPC_OP_IMM));
    emit(i_type(12'h003, 5'd0, 3'b000, 5'd2, rv32_core_pkg::OPC_OP_IMM));
    alu_rr("add", 7'h00, 3'd0, 32'hffff_fffc);
    alu_rr("sub", 7'h20, 3'd0, 32'hffff_fff6);
    alu_rr("sll", 7'h00, 3'd1, 32'hffff_ffc8);
    alu_rr("slt", 7'h00, 3'd2, 32'd1);
    alu_rr("sltu", 7'h00, 3'd3, 32'd0);
    alu_rr("xor", 7'h00, 3'd4, 32'hffff_fffa);
    alu_rr("srl", 7'h00, 3'd5, 32'h1fff_ffff);
    alu_rr("sra", 7'h20, 3'd5, 32'hffff_ffff);
    alu_rr("or", 7'h00, 3'd6, 32'hffff_fffb);
    alu_rr("and", 7'h00, 3'd7, 32'h0000_0001);
    alu_ri("addi", 12'h064, 3'd0, 32'h0000_005d);
    alu_ri("slti", 12'hfff, 3'd2, 32'd1);
    alu_ri("sltiu", 12'hfff, 3'd3, 32'd1);
    alu_ri("xori", 12'h0ff, 3'd4, 32'hffff_ff06);
    alu_ri("ori", 12'h0f2, 3'd6, 32'hffff_fffb);
    alu_ri("andi", 12'h7f0, 3'd7, 32'h0000_07f0);
    alu_ri("slli", 12'h004, 3'd1, 32'hffff_ff90);
    alu_ri("srli", 12'h004, 3'd5, 32'h0fff_ffff);
    alu_ri("srai", 12'h404, 3'd5, 32'hffff_ffff);
    // A write to x0 is dropped.
    emit(i_type(12'h05a, 5'd1, 3'b000, 5'd0, rv32_core_pkg::OPC_OP_IMM));
    check_word("x0_write", 5'd0, 32'd0);
    emit(u_type(20'h12345, 5'd3, rv32_core_pkg::OPC_LUI));
    check_word("lui", 5'd3, 32'h1234_5000);
    here = rv32_core_pkg::word_t'(pc_idx * 4);
    emit(u_type(20'h00001, 5'd3, rv32_core_pkg::OPC_AUIPC));
    check_word("auipc", 5'd3, here + 32'h1000);
    // Backward loop of ten, predicted taken, mispredicted on exit.
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd4, rv32_core_pkg::OPC_OP_IMM));
    emit(i_type(12'd10, 5'd0, 3'b000, 5'd5, rv32_core_pkg::OPC_OP_IMM));
    emit(i_type(12'd1, 5'd4, 3'b000, 5'd4, rv32_core_pkg::OPC_OP_IMM));
    emit(b_type(13'h1ffc, 5'd4, 5'd5, 3'b001));
    check_word("loop_count", 5'd4, 32'd10);
    // Forward branch, not taken, falls through.
    emit(b_type(13'd8, 5'd4, 5'd0, 3'b000));
    emit(i_type(12'h055, 5'd0, 3'b000, 5'd6, rv32_core_pkg::OPC_OP_IMM));
    check_word("fall_through", 5'd6, 32'h55);
    // Forward branch, taken, skips a stray store.
    emit(b_type(13'd8, 5'd0, 5'd0, 3'b000));
    emit(s_type(12'd252, 5'd4, 5'd0, 3'b010));
    emit(i_type(12'h066, 5'd0, 3'b000, 5'd6, rv32_core_pkg::OPC_OP_IMM));
    check_word("branch_target", 5'd6, 32'h66);
    // JAL over one store.
    here = rv32_core_pkg::word_t'(pc_idx * 4);
    emit(j_type(21'd8, 5'd7));
    emit(s_type(12'd252, 5'd7, 5'd0, 3'b010));
    check_word("jal_link", 5'd7, here + 32'd4);
    // JALR to an absolute target, again over one store.
    here = rv32_core_pkg::word_t'(pc_idx * 4);
    emit(i_type(12'(here + 32'd12), 5'd0, 3'b000, 5'd8, rv32_core_pkg::OPC_OP_IMM));
    emit(i_type(12'd0, 5'd8, 3'b000, 5'd9, rv32_core_pkg::OPC_JALR));
    emit(s_type(12'd252, 5'd9, 5'd0, 3'b010));
    check_word("jalr_link", 5'd9, here + 32'd8);
    // Byte stores to every lane of 0xc0.
    emit(i_type(12'h081, 5'd0, 3'b000, 5'd10, rv32_core_pkg::OPC_OP_IMM));
    for (int k = 0; k < 4; k++) begin
      emit(s_type(12'(12'h0c0 + k), 5'd10, 5'd0, 3'b000));
      expect_store($sformatf("sb_lane%0d", k), 32'h0c0 + 32'(k),
                   4'b0001 << k, {4{8'h81}});
    end
    // Half-word stores to both halves of 0xc4.
    emit(u_type(20'h00008, 5'd11, rv32_core_pkg::OPC_LUI));
    emit(i_type(12'h234, 5'd11, 3'b000, 5'd11, rv32_core_pkg::OPC_OP_IMM));
    emit(s_type(12'h0c4, 5'd11, 5'd0, 3'b001));
    expect_store("sh_low", 32'h0c4, 4'b0011, {2{16'h8234}});
    emit(s_type(12'h0c6, 5'd11, 5'd0, 3'b001));
    expect_store("sh_high", 32'h0c6, 4'b1100, {2{16'h8234}});
    // Reload with each extension rule.
    emit(i_type(12'h0c1, 5'd0, 3'b000, 5'd12, rv32_core_pkg::OPC_LOAD));
    check_word("lb", 5'd12, sext8(8'h81));
    emit(i_type(12'h0c2, 5'd0, 3'b100, 5'd12, rv32_core_pkg::OPC_LOAD));
    check_word("lbu", 5'd12, 32'h81);
    emit(i_type(12'h0c6, 5'd0, 3'b001, 5'd12, rv32_core_pkg::OPC_LOAD));
    check_word("lh", 5'd12, sext16(16'h8234));
    emit(i_type(12'h0c4, 5'd0, 3'b101, 5'd12, rv32_core_pkg::OPC_LOAD));
    check_word("lhu", 5'd12, 32'h8234);
    // EBREAK.
    emit(32'h0010_0073);
  endtask

  // Data memory writes complete when busy is low.
  always @(posedge CLK) begin
    if (rst_n && dmem_req.wen && !dmem_busy) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.byte_en[i]) begin
          dmem[dmem_req.addr[7:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Scoreboard. Each completed store must match the head of the queue.
  always @(posedge CLK) begin
    logic [67:0] exp;
    string       name;
    if (rst_n && dmem_req.wen && !dmem_busy) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Unexpected store to address %h", dmem_req.addr);
      end else begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
        assert ({dmem_req.addr, dmem_req.byte_en, dmem_req.wdata} == exp) else begin
          check_errors++;
          $display("CHECK FAILED %s: expected %h actual %h", name, exp,
                   {dmem_req.addr, dmem_req.byte_en, dmem_req.wdata});
        end
      end
    end
  end

  // Request held steady while the memory is busy.
  assert property (@(posedge CLK) disable iff (!rst_n)
    (dmem_busy && (dmem_req.ren || dmem_req.wen)) |=> $stable(dmem_req))
    else begin
      other_errors++;
      $display("Data request changed while memory was busy");
    end

  // Fetch keeps requesting until the core halts.
  assert property (@(posedge CLK) disable iff (!rst_n)
    !halt |-> imem_ren)
    else begin
      other_errors++;
      $display("Instruction fetch stopped before halt");
    end

  // Halt is sticky and silences both ports.
  assert property (@(posedge CLK) disable iff (!rst_n)
    halt |=> (halt && !imem_ren && !dmem_req.ren && !dmem_req.wen))
    else begin
      other_errors++;
      $display("Core left halt or issued a request after halt");
    end

  // Busy high about one cycle in four, two LFSR bits per cycle.
  always @(posedge CLK) begin
    #1;
    busy_bit0 = lfsr[0];
    lfsr      = lfsr_next(lfsr);
    busy_bit1 = lfsr[0];
    lfsr      = lfsr_next(lfsr);
    dmem_busy = busy_bit0 & busy_bit1;
  end

  initial begin
    int cycles;
    rst_n     = 1'b0;
    dmem_busy = 1'b0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'hdead_0000 ^ (32'(i) * 32'h0001_0101);
    end
    build_program();
    repeat (4) @(posedge CLK);
    #1 rst_n = 1'b1;
    cycles = 0;
    while (!halt && cycles < 5000) begin
      @(posedge CLK);
      cycles++;
    end
    if (!halt) begin
      other_errors++;
      $display("Timeout: core did not halt within %0d cycles", cycles);
    end else begin
      // Watch the halted core for a while.
      for (int i = 0; i < 10; i++) begin
        @(posedge CLK);
      end
      assert (exp_q.size() == 0) else begin
        other_errors++;
        $display("%0d expected stores never happened", exp_q.size());
      end
    end
    $display("Errors: check %0d, other %0d", check_errors, other_errors);
    if (check_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* rv32_core.f */
rv32_core_pkg.sv
reg_file.sv
alu.sv
control_unit.sv
branch_unit.sv
hazard_unit.sv
fetch_stage.sv
execute_stage.sv
rv32_core.sv
tb_rv32_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rv32_core
FILELIST = rv32_core.f
LOG      = sim.log

SHELL := /bin/bash

.PHONY: sim clean

sim:
	set -o pipefail; $(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) && \
	./obj_dir/V$(TOP) | tee $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
